// File: common/core_ctl_if.sv
// #################################################
// Decoded controls from ctlpath to datapath.
// All signals are combinational within the cycle
// #################################################

`timescale 1ns/1ps

interface core_ctl_if;

  rv_isa_pkg::alu_function_t      alu_function;
  rv_core_pkg::operand_a_select_t operand_a_select;
  rv_core_pkg::operand_b_select_t operand_b_select;
  rv_core_pkg::writeback_select_t reg_writeback_select;
  rv_core_pkg::next_pc_select_t   next_pc_select;
  logic                           regfile_write_enable;
  logic                           pc_write_enable;

  modport ctlpath (
    output alu_function, operand_a_select, operand_b_select,
    output reg_writeback_select, next_pc_select,
    output regfile_write_enable, pc_write_enable
  );

  modport datapath (
    input alu_function, operand_a_select, operand_b_select,
    input reg_writeback_select, next_pc_select,
    input regfile_write_enable, pc_write_enable
  );

endinterface

// File: common/rv_core_pkg.sv
// #################################################
// Internal control selects of the single-cycle core.
// Reset vector must be word aligned
// #################################################

package rv_core_pkg;

  // Source of the register writeback value
  typedef enum logic [2:0] {
    wb_alu,
    wb_mem,
    wb_pc_plus_4,
    wb_imm
  } writeback_select_t;

  // alu_target is used by jalr, bit 0 cleared
  typedef enum logic [1:0] {
    next_pc_plus_4,
    next_pc_branch_target,
    next_pc_alu_target
  } next_pc_select_t;

  typedef enum logic {
    operand_a_rs1,
    operand_a_pc
  } operand_a_select_t;

  typedef enum logic {
    operand_b_rs2,
    operand_b_imm
  } operand_b_select_t;

  localparam logic [31:0] default_reset_vector = 32'h0000_0000;

endpackage

// File: common/rv_isa_pkg.sv
// #################################################
// RV32I encoding only. No CSR, fence or system
// opcodes, and no M extension
// #################################################

package rv_isa_pkg;

  localparam int xlen = 32;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    opcode_op     = 7'b0110011,
    opcode_op_imm = 7'b0010011,
    opcode_load   = 7'b0000011,
    opcode_store  = 7'b0100011,
    opcode_branch = 7'b1100011,
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111
  } opcode_t;

  // Branch conditions
  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  // Load and store sizes
  localparam logic [2:0] funct3_byte          = 3'b000;
  localparam logic [2:0] funct3_half          = 3'b001;
  localparam logic [2:0] funct3_word          = 3'b010;
  localparam logic [2:0] funct3_byte_unsigned = 3'b100;
  localparam logic [2:0] funct3_half_unsigned = 3'b101;

  // Comparison functions return 1 or 0 in the result word
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ltu,
    alu_ge,
    alu_geu
  } alu_function_t;

endpackage

// File: compile.f
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
common/core_ctl_if.sv
core/register_file.sv
core/data_memory_interface.sv
core/singlecycle_ctlpath.sv
core/singlecycle_datapath.sv
core/riscv_core.sv
verif/riscv_core_checker.sv
verif/riscv_core_tb.sv

// File: core/data_memory_interface.sv
// #################################################
// Lane steering for the data bus. Misaligned halves
// and words are not detected
// #################################################

`timescale 1ns/1ps

module data_memory_interface (
  input  logic [31:0] address,
  input  logic [2:0]  data_format,
  input  logic [31:0] write_data,
  input  logic [31:0] bus_read_data,
  output logic [31:0] bus_write_data,
  output logic [3:0]  bus_byte_enable,
  output logic [31:0] read_data
);

  logic [31:0] lane_data;

  // Stores replicate the value into every lane, enables pick the lane
  always_comb begin
    case (data_format)
      rv_isa_pkg::funct3_byte: begin
        bus_write_data  = {4{write_data[7:0]}};
        bus_byte_enable = 4'b0001 << address[1:0];
      end
      rv_isa_pkg::funct3_half: begin
        bus_write_data  = {2{write_data[15:0]}};
        bus_byte_enable = 4'b0011 << {address[1], 1'b0};
      end
      default: begin
        bus_write_data  = write_data;
        bus_byte_enable = 4'b1111;
      end
    endcase
  end

  // Addressed lane moved down to bit 0
  assign lane_data = bus_read_data >> {address[1:0], 3'b000};

  always_comb begin
    case (data_format)
      rv_isa_pkg::funct3_byte:          read_data = {{24{lane_data[7]}}, lane_data[7:0]};
      rv_isa_pkg::funct3_byte_unsigned: read_data = {24'b0, lane_data[7:0]};
      rv_isa_pkg::funct3_half:          read_data = {{16{lane_data[15]}}, lane_data[15:0]};
      rv_isa_pkg::funct3_half_unsigned: read_data = {16'b0, lane_data[15:0]};
      default:                          read_data = bus_read_data;
    endcase
  end

endmodule

// File: core/register_file.sv
// #################################################
// No reset. Registers read undefined until written,
// x0 always reads zero
// #################################################

`timescale 1ns/1ps

module register_file (
  input  logic        clock,
  input  logic        write_enable,
  input  logic [4:0]  rd_address,
  input  logic [4:0]  rs1_address,
  input  logic [4:0]  rs2_address,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x0 has no storage
  logic [31:0] registers [1:31];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != 5'd0) begin
      registers[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == 5'd0) ? '0 : registers[rs1_address];
  assign rs2_data = (rs2_address == 5'd0) ? '0 : registers[rs2_address];

endmodule

// File: core/riscv_core.sv
// #################################################
// Single-cycle RV32I core. Instruction and data
// memories must answer within the same cycle
// #################################################

`timescale 1ns/1ps

module riscv_core #(
  parameter logic [31:0] reset_vector = rv_core_pkg::default_reset_vector
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic [31:0] bus_read_data,
  output logic [31:0] pc,
  output logic [31:0] alu_result,
  output logic [31:0] bus_write_data,
  output logic [3:0]  bus_byte_enable,
  output logic        bus_write_enable,
  output logic        bus_read_enable
);

  logic [6:0]  inst_opcode;
  logic [2:0]  inst_funct3;
  logic [6:0]  inst_funct7;
  logic [31:0] rs2_data;
  logic [31:0] mem_read_data;
  logic        alu_result_zero;

  core_ctl_if ctl ();

  // Branch decision input for the ctlpath
  assign alu_result_zero = (alu_result == '0);

  singlecycle_ctlpath ctlpath (
    .clock                 (clock),
    .reset                 (reset),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_zero       (alu_result_zero),
    .ctl                   (ctl.ctlpath),
    .data_mem_read_enable  (bus_read_enable),
    .data_mem_write_enable (bus_write_enable)
  );

  singlecycle_datapath #(
    .reset_vector (reset_vector)
  ) datapath (
    .clock              (clock),
    .reset              (reset),
    .inst               (inst),
    .ctl                (ctl.datapath),
    .data_mem_read_data (mem_read_data),
    .inst_opcode        (inst_opcode),
    .inst_funct3        (inst_funct3),
    .inst_funct7        (inst_funct7),
    .alu_result         (alu_result),
    .rs2_data           (rs2_data),
    .pc                 (pc)
  );

  data_memory_interface dmem (
    .address         (alu_result),
    .data_format     (inst_funct3),
    .write_data      (rs2_data),
    .bus_read_data   (bus_read_data),
    .bus_write_data  (bus_write_data),
    .bus_byte_enable (bus_byte_enable),
    .read_data       (mem_read_data)
  );

endmodule

// File: core/singlecycle_ctlpath.sv
// #################################################
// Purely combinational decoder. Illegal opcodes run
// as no-ops, all enables are forced low in reset
// #################################################

`timescale 1ns/1ps

module singlecycle_ctlpath (
  input  logic               clock,
  input  logic               reset,
  input  logic [6:0]         inst_opcode,
  input  logic [2:0]         inst_funct3,
  input  logic [6:0]         inst_funct7,
  input  logic               alu_result_zero,
  core_ctl_if.ctlpath        ctl,
  output logic               data_mem_read_enable,
  output logic               data_mem_write_enable
);

  rv_isa_pkg::alu_function_t op_function;
  rv_isa_pkg::alu_function_t branch_function;
  logic                      reg_write;
  logic                      mem_read;
  logic                      mem_write;

  // OP and OP-IMM share funct3; sub only exists in OP
  always_comb begin
    case (inst_funct3)
      3'b000: begin
        op_function = (inst_opcode == rv_isa_pkg::opcode_op && inst_funct7[5])
                      ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      end
      3'b001: op_function = rv_isa_pkg::alu_sll;
      3'b010: op_function = rv_isa_pkg::alu_slt;
      3'b011: op_function = rv_isa_pkg::alu_sltu;
      3'b100: op_function = rv_isa_pkg::alu_xor;
      3'b101: op_function = inst_funct7[5] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      3'b110: op_function = rv_isa_pkg::alu_or;
      default: op_function = rv_isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    case (inst_funct3)
      rv_isa_pkg::funct3_beq:  branch_function = rv_isa_pkg::alu_eq;
      rv_isa_pkg::funct3_bne:  branch_function = rv_isa_pkg::alu_ne;
      rv_isa_pkg::funct3_blt:  branch_function = rv_isa_pkg::alu_lt;
      rv_isa_pkg::funct3_bge:  branch_function = rv_isa_pkg::alu_ge;
      rv_isa_pkg::funct3_bltu: branch_function = rv_isa_pkg::alu_ltu;
      default:                 branch_function = rv_isa_pkg::alu_geu;
    endcase
  end

  always_comb begin
    ctl.alu_function         = rv_isa_pkg::alu_add;
    ctl.operand_a_select     = rv_core_pkg::operand_a_rs1;
    ctl.operand_b_select     = rv_core_pkg::operand_b_imm;
    ctl.reg_writeback_select = rv_core_pkg::wb_alu;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (inst_opcode)
      rv_isa_pkg::opcode_op: begin
        ctl.alu_function     = op_function;
        ctl.operand_b_select = rv_core_pkg::operand_b_rs2;
        reg_write            = 1'b1;
      end
      rv_isa_pkg::opcode_op_imm: begin
        ctl.alu_function = op_function;
        reg_write        = 1'b1;
      end
      rv_isa_pkg::opcode_load: begin
        ctl.reg_writeback_select = rv_core_pkg::wb_mem;
        mem_read                 = 1'b1;
        reg_write                = 1'b1;
      end
      rv_isa_pkg::opcode_store: mem_write = 1'b1;
      rv_isa_pkg::opcode_branch: begin
        ctl.alu_function     = branch_function;
        ctl.operand_b_select = rv_core_pkg::operand_b_rs2;
      end
      rv_isa_pkg::opcode_lui: begin
        ctl.reg_writeback_select = rv_core_pkg::wb_imm;
        reg_write                = 1'b1;
      end
      rv_isa_pkg::opcode_auipc: begin
        ctl.operand_a_select = rv_core_pkg::operand_a_pc;
        reg_write            = 1'b1;
      end
      rv_isa_pkg::opcode_jal, rv_isa_pkg::opcode_jalr: begin
        ctl.reg_writeback_select = rv_core_pkg::wb_pc_plus_4;
        reg_write                = 1'b1;
      end
      default: ;
    endcase
  end

  // Kept apart from the decoder since it depends on the ALU result
  always_comb begin
    case (inst_opcode)
      rv_isa_pkg::opcode_branch: begin
        ctl.next_pc_select = alu_result_zero ? rv_core_pkg::next_pc_plus_4
                                             : rv_core_pkg::next_pc_branch_target;
      end
      rv_isa_pkg::opcode_jal:  ctl.next_pc_select = rv_core_pkg::next_pc_branch_target;
      rv_isa_pkg::opcode_jalr: ctl.next_pc_select = rv_core_pkg::next_pc_alu_target;
      default:                 ctl.next_pc_select = rv_core_pkg::next_pc_plus_4;
    endcase
  end

  assign ctl.regfile_write_enable = reg_write & ~reset;
  assign ctl.pc_write_enable      = ~reset;
  assign data_mem_read_enable     = mem_read & ~reset;
  assign data_mem_write_enable    = mem_write & ~reset;

endmodule

// File: core/singlecycle_datapath.sv
// #################################################
// Only the pc is registered here. Reset loads
// reset_vector, which must be word aligned
// #################################################

`timescale 1ns/1ps

module singlecycle_datapath #(
  parameter logic [31:0] reset_vector = rv_core_pkg::default_reset_vector
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  core_ctl_if.datapath ctl,
  input  logic [31:0] data_mem_read_data,
  output logic [6:0]  inst_opcode,
  output logic [2:0]  inst_funct3,
  output logic [6:0]  inst_funct7,
  output logic [31:0] alu_result,
  output logic [31:0] rs2_data,
  output logic [31:0] pc
);

  logic [31:0] rs1_data;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] pc_plus_4;
  logic [31:0] writeback_data;
  logic [31:0] next_pc;

  assign inst_opcode = inst[6:0];
  assign inst_funct3 = inst[14:12];
  assign inst_funct7 = inst[31:25];

  // Immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (inst_opcode)
      rv_isa_pkg::opcode_store:                        imm = imm_s;
      rv_isa_pkg::opcode_branch:                       imm = imm_b;
      rv_isa_pkg::opcode_lui, rv_isa_pkg::opcode_auipc: imm = imm_u;
      rv_isa_pkg::opcode_jal:                          imm = imm_j;
      default:                                         imm = imm_i;
    endcase
  end

  register_file regfile (
    .clock        (clock),
    .write_enable (ctl.regfile_write_enable),
    .rd_address   (inst[11:7]),
    .rs1_address  (inst[19:15]),
    .rs2_address  (inst[24:20]),
    .rd_data      (writeback_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (ctl.operand_a_select == rv_core_pkg::operand_a_pc) ? pc : rs1_data;
  assign operand_b = (ctl.operand_b_select == rv_core_pkg::operand_b_imm) ? imm : rs2_data;

  // Shifts use the low five bits of operand b
  always_comb begin
    case (ctl.alu_function)
      rv_isa_pkg::alu_add:    alu_result = operand_a + operand_b;
      rv_isa_pkg::alu_sub:    alu_result = operand_a - operand_b;
      rv_isa_pkg::alu_sll:    alu_result = operand_a << operand_b[4:0];
      rv_isa_pkg::alu_srl:    alu_result = operand_a >> operand_b[4:0];
      rv_isa_pkg::alu_sra:    alu_result = $unsigned($signed(operand_a) >>> operand_b[4:0]);
      rv_isa_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
      rv_isa_pkg::alu_or:     alu_result = operand_a | operand_b;
      rv_isa_pkg::alu_and:    alu_result = operand_a & operand_b;
      rv_isa_pkg::alu_pass_b: alu_result = operand_b;
      rv_isa_pkg::alu_slt,
      rv_isa_pkg::alu_lt:     alu_result = 32'($signed(operand_a) < $signed(operand_b));
      rv_isa_pkg::alu_sltu,
      rv_isa_pkg::alu_ltu:    alu_result = 32'(operand_a < operand_b);
      rv_isa_pkg::alu_eq:     alu_result = 32'(operand_a == operand_b);
      rv_isa_pkg::alu_ne:     alu_result = 32'(operand_a != operand_b);
      rv_isa_pkg::alu_ge:     alu_result = 32'($signed(operand_a) >= $signed(operand_b));
      rv_isa_pkg::alu_geu:    alu_result = 32'(operand_a >= operand_b);
      default:                alu_result = '0;
    endcase
  end

  assign pc_plus_4 = pc + 32'd4;

  always_comb begin
    case (ctl.reg_writeback_select)
      rv_core_pkg::wb_mem:       writeback_data = data_mem_read_data;
      rv_core_pkg::wb_pc_plus_4: writeback_data = pc_plus_4;
      rv_core_pkg::wb_imm:       writeback_data = imm;
      default:                   writeback_data = alu_result;
    endcase
  end

  // Branch and jal targets both add the selected immediate to pc
  always_comb begin
    case (ctl.next_pc_select)
      rv_core_pkg::next_pc_branch_target: next_pc = pc + imm;
      rv_core_pkg::next_pc_alu_target:    next_pc = {alu_result[31:1], 1'b0};
      default:                            next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (ctl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module riscv_core_tb -o riscv_core_sim
./obj_dir/riscv_core_sim | tee sim.log

if grep -q "^Verification passed$" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// File: verif/riscv_core_checker.sv
// ################################################
// Bus and pc properties, bound into riscv_core
// ################################################

`timescale 1ns/1ps

module riscv_core_checker (
  input logic        clock,
  input logic        reset,
  input logic [31:0] pc,
  input logic [3:0]  bus_byte_enable,
  input logic        bus_write_enable,
  input logic        bus_read_enable
);

  no_read_and_write: assert property (@(posedge clock) !(bus_write_enable && bus_read_enable))
    else $error("read and write enables high together");

  write_has_lanes: assert property (@(posedge clock) bus_write_enable |-> bus_byte_enable != 4'b0)
    else $error("write enabled with no byte lane");

  pc_aligned: assert property (@(posedge clock) !reset |-> pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  quiet_in_reset: assert property (@(posedge clock)
                                   reset |-> !bus_write_enable && !bus_read_enable)
    else $error("bus enable high during reset");

endmodule

bind riscv_core riscv_core_checker checker_inst (
  .clock            (clock),
  .reset            (reset),
  .pc               (pc),
  .bus_byte_enable  (bus_byte_enable),
  .bus_write_enable (bus_write_enable),
  .bus_read_enable  (bus_read_enable)
);

// File: verif/riscv_core_tb.sv
// ################################################
// Directed tests with a 64-word ROM and RAM model.
// Data addresses stay below 256 bytes
// ################################################

`timescale 1ns/1ps

module riscv_core_tb;

  // Reset, alu, byte, branch and jump budgets, plus margin
  localparam int cycle_limit = 15 + 49 + 50 + 18 * 10 + 14 + 80;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] inst;
  logic [31:0] bus_read_data;
  logic [31:0] pc;
  logic [31:0] alu_result;
  logic [31:0] bus_write_data;
  logic [3:0]  bus_byte_enable;
  logic        bus_write_enable;
  logic        bus_read_enable;
  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];
  int          rom_index;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [2:0]  op_funct3 [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic        op_alt [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  logic [2:0]  branch_funct3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  always #4 clock = ~clock;

  riscv_core dut (
    .clock            (clock),
    .reset            (reset),
    .inst             (inst),
    .bus_read_data    (bus_read_data),
    .pc               (pc),
    .alu_result       (alu_result),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_enable  (bus_read_enable)
  );

  // Both memories answer combinationally
  assign inst          = rom[pc[7:2]];

  // Read data is inverted unless the read enable is high
  assign bus_read_data = bus_read_enable ? ram[alu_result[7:2]] : ~ram[alu_result[7:2]];

  always @(posedge clock) begin
    if (bus_write_enable) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_byte_enable[i]) ram[alu_result[7:2]][8*i +: 8] = bus_write_data[8*i +: 8];
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    enc_s = {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_isa_pkg::opcode_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv_isa_pkg::opcode_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    enc_u = {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::opcode_jal};
  endfunction

  // Reference results from the RV32I rules
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: ref_alu = alt ? a - b : a + b;
      3'd1: ref_alu = a << b[4:0];
      3'd2: ref_alu = {31'b0, $signed(a) < $signed(b)};
      3'd3: ref_alu = {31'b0, a < b};
      3'd4: ref_alu = a ^ b;
      3'd5: ref_alu = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: ref_alu = a | b;
      default: ref_alu = a & b;
    endcase
  endfunction

  function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [31:0] w,
                                           input logic [1:0] off);
    logic [31:0] lane;
    lane = w >> {off, 3'b000};
    case (f3)
      3'd0: ref_load = {{24{lane[7]}}, lane[7:0]};
      3'd4: ref_load = {24'b0, lane[7:0]};
      3'd1: ref_load = {{16{lane[15]}}, lane[15:0]};
      3'd5: ref_load = {16'b0, lane[15:0]};
      default: ref_load = w;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: ref_branch = (a == b);
      3'd1: ref_branch = (a != b);
      3'd4: ref_branch = ($signed(a) < $signed(b));
      3'd5: ref_branch = ($signed(a) >= $signed(b));
      3'd6: ref_branch = (a < b);
      default: ref_branch = (a >= b);
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    rom[rom_index] = word;
    rom_index++;
  endtask

  // lui plus addi, upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(enc_u(upper[19:0], rd, rv_isa_pkg::opcode_lui));
    emit(enc_i(value[11:0], rd, 3'd0, rd, rv_isa_pkg::opcode_op_imm));
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  // Filler is addi x0, x0, index so every word differs
  task automatic start_test();
    reset = 1'b1;
    rom_index = 0;
    for (int i = 0; i < 64; i++) begin
      rom[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, rv_isa_pkg::opcode_op_imm);
      ram[i] = {16'hd00d, 10'b0, 6'(i)};
    end
  endtask

  task automatic run_program(input int cycles);
    repeat (5) step();
    reset = 1'b0;
    repeat (cycles) step();
  endtask

  task automatic test_reset();
    start_test();
    // Store at the reset vector must stay blocked while reset is high
    emit(enc_s(12'd0, 5'd0, rv_isa_pkg::funct3_word));
    repeat (5) begin
      step();
      check("reset pc", rv_core_pkg::default_reset_vector, pc);
      check("reset enables", 32'd0, {30'b0, bus_write_enable, bus_read_enable});
    end
    check("reset ram", {16'hd00d, 16'h0000}, ram[0]);
    reset = 1'b0;
    #1;
    check("release pc", rv_core_pkg::default_reset_vector, pc);
    check("release enables", 32'd2, {30'b0, bus_write_enable, bus_read_enable});
    repeat (10) step();
    check("straight pc", rv_core_pkg::default_reset_vector + 32'd40, pc);
    check("first store", 32'd0, ram[0]);
  endtask

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_b;
    logic [11:0] imm12;
    logic [31:0] expected [0:19];
    int          slot;
    start_test();
    a = $urandom;
    b = $urandom;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      emit(enc_r(op_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, op_funct3[k], 5'd3));
      emit(enc_s(12'(4 * k), 5'd3, rv_isa_pkg::funct3_word));
      expected[k] = ref_alu(op_funct3[k], op_alt[k], a, b);
    end
    slot = 10;
    for (int k = 0; k < 10; k++) begin
      if (k != 1) begin
        if (op_funct3[k] == 3'd1 || op_funct3[k] == 3'd5) begin
          imm12 = {op_alt[k] ? 7'h20 : 7'h00, 5'($urandom)};
          imm_b = {27'b0, imm12[4:0]};
        end else begin
          imm12 = 12'($urandom);
          imm_b = {{20{imm12[11]}}, imm12};
        end
        emit(enc_i(imm12, 5'd1, op_funct3[k], 5'd3, rv_isa_pkg::opcode_op_imm));
        emit(enc_s(12'(4 * slot), 5'd3, rv_isa_pkg::funct3_word));
        expected[slot] = ref_alu(op_funct3[k], op_alt[k], a, imm_b);
        slot++;
      end
    end
    // x0 must stay zero after a write attempt
    emit(enc_i(12'd5, 5'd1, 3'd0, 5'd0, rv_isa_pkg::opcode_op_imm));
    emit(enc_s(12'(4 * slot), 5'd0, rv_isa_pkg::funct3_word));
    expected[slot] = 32'd0;
    run_program(rom_index);
    for (int s = 0; s < 20; s++) check("alu", expected[s], ram[s]);
  endtask

  task automatic test_byte_half();
    logic [31:0] w;
    logic [31:0] b;
    logic [31:0] h;
    logic [31:0] expected [0:20];
    logic [2:0]  f3;
    logic [1:0]  off;
    start_test();
    // Lanes 0 and 3 negative, lanes 1 and 2 positive
    w = ($urandom & 32'h7f7f_7f7f) | 32'h8000_0080;
    b = $urandom;
    h = $urandom;
    load_const(5'd1, w);
    load_const(5'd2, b);
    load_const(5'd3, h);
    emit(enc_s(12'd0, 5'd1, rv_isa_pkg::funct3_word));
    expected[0] = w;
    for (int l = 0; l < 4; l++) begin
      emit(enc_s(12'(4 * (1 + l)), 5'd1, rv_isa_pkg::funct3_word));
      emit(enc_s(12'(4 * (1 + l) + l), 5'd2, rv_isa_pkg::funct3_byte));
      expected[1 + l] = w;
      expected[1 + l][8*l +: 8] = b[7:0];
    end
    for (int l = 0; l < 2; l++) begin
      emit(enc_s(12'(4 * (5 + l)), 5'd1, rv_isa_pkg::funct3_word));
      emit(enc_s(12'(4 * (5 + l) + 2 * l), 5'd3, rv_isa_pkg::funct3_half));
      expected[5 + l] = w;
      expected[5 + l][16*l +: 16] = h[15:0];
    end
    for (int i = 0; i < 13; i++) begin
      if (i < 4) begin
        f3 = rv_isa_pkg::funct3_byte;
        off = 2'(i);
      end else if (i < 8) begin
        f3 = rv_isa_pkg::funct3_byte_unsigned;
        off = 2'(i - 4);
      end else if (i < 10) begin
        f3 = rv_isa_pkg::funct3_half;
        off = 2'(2 * (i - 8));
      end else if (i < 12) begin
        f3 = rv_isa_pkg::funct3_half_unsigned;
        off = 2'(2 * (i - 10));
      end else begin
        f3 = rv_isa_pkg::funct3_word;
        off = 2'd0;
      end
      emit(enc_i({10'b0, off}, 5'd0, f3, 5'd4, rv_isa_pkg::opcode_load));
      emit(enc_s(12'(4 * (8 + i)), 5'd4, rv_isa_pkg::funct3_word));
      expected[8 + i] = ref_load(f3, w, off);
    end
    run_program(rom_index);
    for (int s = 0; s < 21; s++) begin
      if (s != 7) check("byte half", expected[s], ram[s]);
    end
  endtask

  task automatic test_branches();
    logic [31:0] neg;
    logic [31:0] pos;
    logic [31:0] a;
    logic [31:0] b;
    neg = 32'h8000_0000 | $urandom;
    pos = $urandom & 32'h7fff_ffff;
    for (int kind = 0; kind < 6; kind++) begin
      for (int pair = 0; pair < 3; pair++) begin
        a = (pair == 1) ? neg : pos;
        b = (pair == 2) ? neg : pos;
        start_test();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_b(13'd12, branch_funct3[kind]));
        run_program(4);
        check("branch pc", 32'd16, pc);
        step();
        check("branch target", ref_branch(branch_funct3[kind], a, b) ? 32'd28 : 32'd20, pc);
      end
    end
  endtask

  task automatic test_jumps();
    logic [19:0] lui_imm;
    logic [19:0] auipc_imm;
    lui_imm = 20'($urandom);
    auipc_imm = 20'($urandom);
    start_test();
    emit(enc_u(lui_imm, 5'd6, rv_isa_pkg::opcode_lui));
    emit(enc_u(auipc_imm, 5'd5, rv_isa_pkg::opcode_auipc));
    emit(enc_j(21'd12, 5'd1));
    rom_index = 5;
    emit(enc_i(12'd45, 5'd0, 3'd0, 5'd7, rv_isa_pkg::opcode_op_imm));
    emit(enc_i(12'd4, 5'd7, 3'd0, 5'd2, rv_isa_pkg::opcode_jalr));
    rom_index = 12;
    emit(enc_s(12'd0, 5'd1, rv_isa_pkg::funct3_word));
    emit(enc_s(12'd4, 5'd2, rv_isa_pkg::funct3_word));
    emit(enc_s(12'd8, 5'd5, rv_isa_pkg::funct3_word));
    emit(enc_s(12'd12, 5'd6, rv_isa_pkg::funct3_word));
    run_program(5);
    check("jalr pc", (32'd45 + 32'd4) & ~32'd1, pc);
    repeat (4) step();
    check("jal link", 32'd8 + 32'd4, ram[0]);
    check("jalr link", 32'd24 + 32'd4, ram[1]);
    check("auipc", 32'd4 + {auipc_imm, 12'b0}, ram[2]);
    check("lui", {lui_imm, 12'b0}, ram[3]);
  endtask

  initial begin
    void'($urandom(32'h56c8));
    test_reset();
    test_alu();
    test_byte_half();
    test_branches();
    test_jumps();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule
